/* compile.f */
+incdir+src
+incdir+tests
src/rd_guard_pkg.sv
src/rd_sample_unit.sv
src/rd_txn_queue.sv
src/rd_phase_timer.sv
src/rd_fault_log.sv
src/rd_guard_top.sv
tests/tb_rd_guard.sv

/* run.sh */
#!/bin/sh
# Build and run the read guard testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_rd_guard \
  -Mdir obj_dir -o sim_rd_guard > build.log 2>&1 \
  && ./obj_dir/sim_rd_guard > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "SIMULATION FAILED" sim.log && { echo "Test failed, see sim.log"; exit 1; } \
  || { echo "Test passed"; exit 0; }

/* tests/tb_rd_guard_cases.svh */
/*
 * Case table of the read guard testbench, included inside the testbench module.
 * Each row gives the bus timing in cycles, the budgets and the expected results.
 */
`ifndef TB_RD_GUARD_CASES_SVH
`define TB_RD_GUARD_CASES_SVH

// Cause bits in order ar_rdy, ar_r, r_rdy, r_last, unwanted
typedef struct packed {
  int                         n_reads;
  int                         ahead_len;
  int                         len;
  int                         ar_dly;
  int                         rv_dly;
  int                         rr_dly;
  int                         gap;
  bit                         bad_id;
  bit                         track;
  int                         b_ar;
  int                         b_unit;
  int                         b_rrdy;
  rd_guard_pkg::fault_cause_t exp_cause;
  bit                         exp_rst;
  bit                         exp_rec;
  bit                         exp_lat;
} case_t;

localparam int NumCases = 8;

// Reads ahead of the last one use ahead_len, the last read uses len
function automatic case_t case_row(input int i);
  case_t c;
  c = '0;
  case (i)
    // Single fast read, latencies checked
    0: c = '{1, 0, 1, 8, 12, 8, 8, 1'b0, 1'b1, 10, 20, 10, 5'b00000, 1'b0, 1'b0, 1'b1};
    // Late AR ready
    1: c = '{1, 0, 0, 40, 20, 0, 0, 1'b0, 1'b1, 4, 20, 10, 5'b10000, 1'b1, 1'b1, 1'b0};
    // Slow R ready, interrupt only
    2: c = '{1, 0, 0, 1, 4, 60, 0, 1'b0, 1'b1, 10, 100, 4, 5'b00100, 1'b0, 1'b1, 1'b0};
    // Slow beats, small unit budget
    3: c = '{1, 0, 3, 1, 4, 0, 59, 1'b0, 1'b1, 10, 8, 20, 5'b00010, 1'b1, 1'b1, 1'b0};
    // Same beats behind three single-beat reads
    4: c = '{4, 0, 3, 0, 4, 0, 59, 1'b0, 1'b1, 10, 8, 20, 5'b00000, 1'b0, 1'b0, 1'b0};
    // Last beat with a wrong ID
    5: c = '{1, 0, 0, 1, 4, 1, 0, 1'b1, 1'b1, 10, 20, 10, 5'b00001, 1'b1, 1'b0, 1'b0};
    // Last beat with nothing tracked
    6: c = '{1, 0, 0, 1, 4, 1, 0, 1'b0, 1'b0, 10, 20, 10, 5'b00001, 1'b1, 1'b0, 1'b0};
    // Four reads in flight
    default: c = '{4, 1, 1, 1, 4, 1, 4, 1'b0, 1'b1, 10, 20, 10, 5'b00000, 1'b0, 1'b0, 1'b0};
  endcase
  return c;
endfunction

`endif

/* tests/tb_rd_guard.sv */
/*
 * Testbench of the read guard. Applies the case table to the AR and R
 * channels, checks causes, record and latencies, and prints a summary.
 */
`timescale 1ns/1ps
`include "rd_guard_defines.svh"

module tb_rd_guard;

  localparam int Div = `RG_PRESCALE_DIV;

  `include "tb_rd_guard_cases.svh"

  logic                       clk_i, rst_ni, rd_en_i, reset_clear_i;
  logic                       ar_valid_i, ar_ready_i, r_valid_i, r_ready_i, r_last_i;
  logic [`RG_ID_W-1:0]        ar_id_i, r_id_i, fault_id_o;
  logic [`RG_ADDR_W-1:0]      ar_addr_i, fault_addr_o;
  logic [`RG_LEN_W-1:0]       ar_len_i;
  logic [`RG_HS_CNT_W-1:0]    budget_ar_i, budget_unit_r_i, budget_r_rdy_i;
  logic [`RG_HS_CNT_W-1:0]    lat_ar_rdy_o, lat_r_rdy_o;
  logic [`RG_CNT_W-1:0]       lat_ar_r_o, lat_r_last_o;
  logic                       irq_o, reset_req_o;
  rd_guard_pkg::fault_cause_t fault_cause_o;

  int edge_n, cycles, cycle_limit, irq_count, err_count, pass_count, fail_count;
  bit req_seen;
  logic [`RG_ID_W-1:0]   ids   [`RG_MAX_TXNS];
  logic [`RG_ADDR_W-1:0] addrs [`RG_MAX_TXNS];

  rd_guard_top uut (
    .clk_i, .rst_ni, .rd_en_i, .ar_valid_i, .ar_ready_i, .ar_id_i, .ar_addr_i,
    .ar_len_i, .r_valid_i, .r_ready_i, .r_last_i, .r_id_i, .budget_ar_i,
    .budget_unit_r_i, .budget_r_rdy_i, .reset_clear_i, .irq_o, .reset_req_o,
    .fault_cause_o, .fault_id_o, .fault_addr_o, .lat_ar_rdy_o, .lat_ar_r_o,
    .lat_r_rdy_o, .lat_r_last_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Outputs are sampled mid-cycle, away from the driving edge
  always @(negedge clk_i) begin
    cycles = cycles + 1;
    if (irq_o) irq_count = irq_count + 1;
    if (reset_req_o) req_seen = 1'b1;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic step();
    @(posedge clk_i);
    edge_n = edge_n + 1;
  endtask

  // A last beat in a tick cycle would also be seen in the next window
  task automatic align_beat();
    while (edge_n % Div == Div - 1) step();
  endtask

  task automatic check_cause(input rd_guard_pkg::fault_cause_t got,
                             input rd_guard_pkg::fault_cause_t exp);
    if (got !== exp) begin
      $display("Error at %0t: fault cause %b, expected %b", $time, got, exp);
      err_count = err_count + 1;
    end
  endtask

  task automatic check_record(input logic [`RG_ID_W-1:0] got_id,
                              input logic [`RG_ID_W-1:0] exp_id,
                              input logic [`RG_ADDR_W-1:0] got_addr,
                              input logic [`RG_ADDR_W-1:0] exp_addr);
    if (got_id !== exp_id || got_addr !== exp_addr) begin
      $display("Error at %0t: fault record id %h addr %h, expected id %h addr %h",
               $time, got_id, got_addr, exp_id, exp_addr);
      err_count = err_count + 1;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      err_count = err_count + 1;
    end
  endtask

  // The prescaler phase may move a count by one tick
  task automatic check_latency(input string name, input logic [`RG_CNT_W-1:0] got,
                               input int delay);
    int exp;
    int diff;
    exp  = delay / Div;
    diff = int'(got) - exp;
    if (diff > 1 || diff < -1) begin
      $display("Error at %0t: latency %s is %0d ticks, expected about %0d",
               $time, name, got, exp);
      err_count = err_count + 1;
    end
  endtask

  task automatic clear_faults();
    reset_clear_i <= 1'b1;
    step();
    reset_clear_i <= 1'b0;
    step();
    @(negedge clk_i);
    check_flag("reset request after clear", reset_req_o, 1'b0);
    req_seen  = 1'b0;
    irq_count = 0;
    step();
  endtask

  task automatic drive_ar(input int k, input int len_k, input case_t c);
    ids[k]   = `RG_ID_W'($urandom);
    addrs[k] = $urandom;
    ar_valid_i <= 1'b1;
    ar_id_i    <= ids[k];
    ar_addr_i  <= addrs[k];
    ar_len_i   <= `RG_LEN_W'(len_k);
    repeat (c.ar_dly) step();
    ar_ready_i <= 1'b1;
    step();
    ar_valid_i <= 1'b0;
    ar_ready_i <= 1'b0;
    step();
  endtask

  // Beats stop once the guard has asked for a reset
  task automatic drive_r(input int k, input int len_k, input case_t c);
    logic [`RG_ID_W-1:0] rid;
    rid = c.bad_id ? (ids[k] ^ `RG_ID_W'(1)) : ids[k];
    repeat (c.rv_dly) step();
    if (req_seen) return;
    r_valid_i <= 1'b1;
    r_id_i    <= rid;
    r_last_i  <= (len_k == 0);
    repeat (c.rr_dly) step();
    if (len_k == 0) align_beat();
    r_ready_i <= 1'b1;
    step();
    r_valid_i <= 1'b0;
    r_ready_i <= 1'b0;
    r_last_i  <= 1'b0;
    for (int b = 1; b <= len_k; b++) begin
      repeat (c.gap) step();
      if (req_seen) return;
      if (b == len_k) align_beat();
      r_valid_i <= 1'b1;
      r_ready_i <= 1'b1;
      r_last_i  <= (b == len_k);
      step();
      r_valid_i <= 1'b0;
      r_ready_i <= 1'b0;
      r_last_i  <= 1'b0;
    end
  endtask

  function automatic int row_cycles(input case_t c);
    return c.n_reads * (c.ar_dly + c.rv_dly + c.rr_dly + 8) + c.len * (c.gap + 2) +
           (c.n_reads - 1) * c.ahead_len * (c.gap + 2) + 4 * Div + 8;
  endfunction

  task automatic run_case(input int t, input case_t c);
    int errs_before;
    errs_before = err_count;
    clear_faults();
    rd_en_i         <= c.track;
    budget_ar_i     <= `RG_HS_CNT_W'(c.b_ar);
    budget_unit_r_i <= `RG_HS_CNT_W'(c.b_unit);
    budget_r_rdy_i  <= `RG_HS_CNT_W'(c.b_rrdy);
    step();
    for (int k = 0; k < c.n_reads; k++) begin
      drive_ar(k, (k == c.n_reads - 1) ? c.len : c.ahead_len, c);
    end
    for (int k = 0; k < c.n_reads; k++) begin
      drive_r(k, (k == c.n_reads - 1) ? c.len : c.ahead_len, c);
    end
    // Completion or fault shows within one tick window
    repeat (3 * Div) step();
    @(negedge clk_i);
    check_cause(fault_cause_o, c.exp_cause);
    check_flag("reset request", reset_req_o, c.exp_rst);
    check_flag("interrupt seen", irq_count != 0, c.exp_cause != '0);
    if (c.exp_rec) begin
      check_record(fault_id_o, ids[c.n_reads-1], fault_addr_o, addrs[c.n_reads-1]);
    end
    if (c.exp_lat) begin
      check_latency("ar_rdy", `RG_CNT_W'(lat_ar_rdy_o), c.ar_dly);
      check_latency("ar_r", lat_ar_r_o, c.rv_dly + c.rr_dly);
      check_latency("r_rdy", `RG_CNT_W'(lat_r_rdy_o), c.rr_dly);
      check_latency("r_last", lat_r_last_o, c.len * (c.gap + 1));
    end
    if (err_count == errs_before) begin
      $display("Test %0d: PASS", t);
      pass_count = pass_count + 1;
    end else begin
      $display("Test %0d: FAIL", t);
      fail_count = fail_count + 1;
    end
    step();
  endtask

  initial begin
    void'($urandom(32'h37b68d20));
    cycle_limit = 200;
    for (int t = 0; t < NumCases; t++) cycle_limit = cycle_limit + row_cycles(case_row(t));
    cycles = 0;
    edge_n = 0;
    irq_count = 0;
    err_count = 0;
    pass_count = 0;
    fail_count = 0;
    req_seen = 1'b0;
    rst_ni = 1'b0;
    rd_en_i = 1'b0;
    reset_clear_i = 1'b0;
    ar_valid_i = 1'b0;
    ar_ready_i = 1'b0;
    ar_id_i = '0;
    ar_addr_i = '0;
    ar_len_i = '0;
    r_valid_i = 1'b0;
    r_ready_i = 1'b0;
    r_last_i = 1'b0;
    r_id_i = '0;
    budget_ar_i = '0;
    budget_unit_r_i = '0;
    budget_r_rdy_i = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    edge_n = 0;
    for (int t = 0; t < NumCases; t++) run_case(t, case_row(t));
    $display("Tests: %0d passed, %0d failed, %0d check errors",
             pass_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* src/rd_guard_top.sv */
/*
 * Passive read-channel guard. Observes AR and R handshakes, times each
 * tracked read and reports faults, reset requests and latencies.
 */
`timescale 1ns/1ps
`include "rd_guard_defines.svh"

module rd_guard_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        rd_en_i,
  input  logic                        ar_valid_i,
  input  logic                        ar_ready_i,
  input  logic [`RG_ID_W-1:0]         ar_id_i,
  input  logic [`RG_ADDR_W-1:0]       ar_addr_i,
  input  logic [`RG_LEN_W-1:0]        ar_len_i,
  input  logic                        r_valid_i,
  input  logic                        r_ready_i,
  input  logic                        r_last_i,
  input  logic [`RG_ID_W-1:0]         r_id_i,
  input  logic [`RG_HS_CNT_W-1:0]     budget_ar_i,
  input  logic [`RG_HS_CNT_W-1:0]     budget_unit_r_i,
  input  logic [`RG_HS_CNT_W-1:0]     budget_r_rdy_i,
  input  logic                        reset_clear_i,
  output logic                        irq_o,
  output logic                        reset_req_o,
  output rd_guard_pkg::fault_cause_t  fault_cause_o,
  output logic [`RG_ID_W-1:0]         fault_id_o,
  output logic [`RG_ADDR_W-1:0]       fault_addr_o,
  output logic [`RG_HS_CNT_W-1:0]     lat_ar_rdy_o,
  output logic [`RG_CNT_W-1:0]        lat_ar_r_o,
  output logic [`RG_HS_CNT_W-1:0]     lat_r_rdy_o,
  output logic [`RG_CNT_W-1:0]        lat_r_last_o
);

  rd_guard_pkg::rd_txn_t [`RG_MAX_TXNS-1:0] slots;
  rd_guard_pkg::fault_cause_t               cause;

  logic                     push;
  logic                     tick, arv_s, arr_s, rv_s, rr_s, rl_s;
  logic [`RG_MAX_TXNS-1:0]  slot_valid;
  logic [`RG_SLOT_W-1:0]    head_slot, alloc_slot;
  logic                     alloc, pop, flush, fault, done;
  logic [`RG_ID_W-1:0]      fault_id;
  logic [`RG_ADDR_W-1:0]    fault_addr;
  logic [`RG_HS_CNT_W-1:0]  lat_ar_rdy, lat_r_rdy;
  logic [`RG_CNT_W-1:0]     lat_ar_r, lat_r_last;

  // Track only reads the enable selects, at their AR handshake
  assign push = ar_valid_i && ar_ready_i && rd_en_i;

  rd_sample_unit i_sample (
    .clk_i, .rst_ni, .ar_valid_i, .ar_ready_i, .r_valid_i, .r_ready_i, .r_last_i,
    .tick_o (tick), .arv_o (arv_s), .arr_o (arr_s),
    .rv_o   (rv_s), .rr_o  (rr_s),  .rl_o  (rl_s)
  );

  rd_txn_queue i_queue (
    .clk_i, .rst_ni, .push_i (push), .ar_id_i, .ar_addr_i, .ar_len_i, .budget_unit_r_i,
    .pop_i (pop), .flush_i (flush), .slot_valid_o (slot_valid), .slots_o (slots),
    .head_o (head_slot), .alloc_o (alloc), .alloc_slot_o (alloc_slot)
  );

  rd_phase_timer i_timer (
    .clk_i, .rst_ni, .tick_i (tick), .arv_i (arv_s), .arr_i (arr_s),
    .rv_i (rv_s), .rr_i (rr_s), .rl_i (rl_s), .r_id_i,
    .slot_valid_i (slot_valid), .slots_i (slots), .head_i (head_slot),
    .alloc_i (alloc), .alloc_slot_i (alloc_slot), .budget_ar_i, .budget_r_rdy_i,
    .pop_o (pop), .flush_o (flush), .fault_o (fault), .fault_cause_o (cause),
    .fault_id_o (fault_id), .fault_addr_o (fault_addr), .done_o (done),
    .lat_ar_rdy_o (lat_ar_rdy), .lat_ar_r_o (lat_ar_r),
    .lat_r_rdy_o (lat_r_rdy), .lat_r_last_o (lat_r_last)
  );

  rd_fault_log i_log (
    .clk_i, .rst_ni, .fault_i (fault), .fault_cause_i (cause),
    .fault_id_i (fault_id), .fault_addr_i (fault_addr), .done_i (done),
    .lat_ar_rdy_i (lat_ar_rdy), .lat_ar_r_i (lat_ar_r),
    .lat_r_rdy_i (lat_r_rdy), .lat_r_last_i (lat_r_last), .reset_clear_i,
    .irq_o, .reset_req_o, .fault_cause_o, .fault_id_o, .fault_addr_o,
    .lat_ar_rdy_o, .lat_ar_r_o, .lat_r_rdy_o, .lat_r_last_o
  );

endmodule

/* src/rd_fault_log.sv */
/*
 * Fault and latency record of the read guard. Pulses the interrupt,
 * holds the reset request until cleared and keeps the last clean latencies.
 */
`timescale 1ns/1ps
`include "rd_guard_defines.svh"

module rd_fault_log (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        fault_i,
  input  rd_guard_pkg::fault_cause_t  fault_cause_i,
  input  logic [`RG_ID_W-1:0]         fault_id_i,
  input  logic [`RG_ADDR_W-1:0]       fault_addr_i,
  input  logic                        done_i,
  input  logic [`RG_HS_CNT_W-1:0]     lat_ar_rdy_i,
  input  logic [`RG_CNT_W-1:0]        lat_ar_r_i,
  input  logic [`RG_HS_CNT_W-1:0]     lat_r_rdy_i,
  input  logic [`RG_CNT_W-1:0]        lat_r_last_i,
  input  logic                        reset_clear_i,
  output logic                        irq_o,
  output logic                        reset_req_o,
  output rd_guard_pkg::fault_cause_t  fault_cause_o,
  output logic [`RG_ID_W-1:0]         fault_id_o,
  output logic [`RG_ADDR_W-1:0]       fault_addr_o,
  output logic [`RG_HS_CNT_W-1:0]     lat_ar_rdy_o,
  output logic [`RG_CNT_W-1:0]        lat_ar_r_o,
  output logic [`RG_HS_CNT_W-1:0]     lat_r_rdy_o,
  output logic [`RG_CNT_W-1:0]        lat_r_last_o
);

  logic severe;
  logic rec_held_q;

  assign severe = fault_i && rd_guard_pkg::is_severe(fault_cause_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_o         <= 1'b0;
      reset_req_o   <= 1'b0;
      fault_cause_o <= '0;
      rec_held_q    <= 1'b0;
      fault_id_o    <= '0;
      fault_addr_o  <= '0;
      lat_ar_rdy_o  <= '0;
      lat_ar_r_o    <= '0;
      lat_r_rdy_o   <= '0;
      lat_r_last_o  <= '0;
    end else begin
      irq_o <= fault_i;

      // A severe fault in the clear cycle keeps the request up
      if (severe) begin
        reset_req_o <= 1'b1;
      end else if (reset_clear_i) begin
        reset_req_o <= 1'b0;
      end

      // Cause bits are zero without a fault
      if (reset_clear_i) begin
        fault_cause_o <= fault_cause_i;
      end else begin
        fault_cause_o <= fault_cause_o | fault_cause_i;
      end

      // First fault after a clear owns the ID and address
      if (fault_i && (!rec_held_q || reset_clear_i)) begin
        rec_held_q   <= 1'b1;
        fault_id_o   <= fault_id_i;
        fault_addr_o <= fault_addr_i;
      end else if (reset_clear_i) begin
        rec_held_q <= 1'b0;
      end

      if (done_i) begin
        lat_ar_rdy_o <= lat_ar_rdy_i;
        lat_ar_r_o   <= lat_ar_r_i;
        lat_r_rdy_o  <= lat_r_rdy_i;
        lat_r_last_o <= lat_r_last_i;
      end
    end
  end

  // Software must clear the request, it never drops on its own
  reset_req_hold_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $fell(reset_req_o) |-> $past(reset_clear_i)
  );

endmodule

/* src/rd_phase_timer.sv */
/*
 * Per-slot phase tracking and tick counters. Compares each phase against
 * its budget, reports faults and clean completions, and pops or flushes.
 */
`timescale 1ns/1ps
`include "rd_guard_defines.svh"

module rd_phase_timer (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      tick_i,
  input  logic                                      arv_i,
  input  logic                                      arr_i,
  input  logic                                      rv_i,
  input  logic                                      rr_i,
  input  logic                                      rl_i,
  input  logic [`RG_ID_W-1:0]                       r_id_i,
  input  logic [`RG_MAX_TXNS-1:0]                   slot_valid_i,
  input  rd_guard_pkg::rd_txn_t [`RG_MAX_TXNS-1:0]  slots_i,
  input  logic [`RG_SLOT_W-1:0]                     head_i,
  input  logic                                      alloc_i,
  input  logic [`RG_SLOT_W-1:0]                     alloc_slot_i,
  input  logic [`RG_HS_CNT_W-1:0]                   budget_ar_i,
  input  logic [`RG_HS_CNT_W-1:0]                   budget_r_rdy_i,
  output logic                                      pop_o,
  output logic                                      flush_o,
  output logic                                      fault_o,
  output rd_guard_pkg::fault_cause_t                fault_cause_o,
  output logic [`RG_ID_W-1:0]                       fault_id_o,
  output logic [`RG_ADDR_W-1:0]                     fault_addr_o,
  output logic                                      done_o,
  output logic [`RG_HS_CNT_W-1:0]                   lat_ar_rdy_o,
  output logic [`RG_CNT_W-1:0]                      lat_ar_r_o,
  output logic [`RG_HS_CNT_W-1:0]                   lat_r_rdy_o,
  output logic [`RG_CNT_W-1:0]                      lat_r_last_o
);

  localparam int Depth = `RG_MAX_TXNS;
  localparam int SlotW = `RG_SLOT_W;
  localparam int HsW   = `RG_HS_CNT_W;
  localparam int CntW  = `RG_CNT_W;

  rd_guard_pkg::rd_phase_e phase_q [Depth];

  logic            tmo_q        [Depth];
  logic [HsW-1:0]  cnt_ar_rdy_q [Depth];
  logic [CntW-1:0] cnt_ar_r_q   [Depth];
  logic [HsW-1:0]  cnt_r_rdy_q  [Depth];
  logic [CntW-1:0] cnt_r_last_q [Depth];
  logic [HsW-1:0]  ar_wait_q;

  logic [Depth-1:0] armed;
  logic [Depth-1:0] f_ar_rdy;
  logic [Depth-1:0] f_ar_r;
  logic [Depth-1:0] f_r_rdy;
  logic [Depth-1:0] f_r_last;
  logic [Depth-1:0] slot_fault;
  logic             last_beat;
  logic             head_match;
  logic             complete;

  // Responses come back in issue order, so a last beat belongs to the head
  assign last_beat  = tick_i && rv_i && rr_i && rl_i;
  assign head_match = slot_valid_i[head_i] && (slots_i[head_i].id == r_id_i);
  assign complete   = last_beat && head_match;

  always_comb begin
    for (int i = 0; i < Depth; i++) begin
      armed[i]    = tick_i && slot_valid_i[i] && !tmo_q[i];
      f_ar_rdy[i] = armed[i] && (phase_q[i] == rd_guard_pkg::PH_ADDR) &&
                    (cnt_ar_rdy_q[i] > budget_ar_i);
      f_ar_r[i]   = armed[i] && (phase_q[i] == rd_guard_pkg::PH_ADDR) &&
                    (cnt_ar_r_q[i] > slots_i[i].budget_first);
      f_r_rdy[i]  = armed[i] && (cnt_r_rdy_q[i] > budget_r_rdy_i);
      f_r_last[i] = armed[i] && (phase_q[i] == rd_guard_pkg::PH_DATA) &&
                    (cnt_r_last_q[i] > slots_i[i].budget_last);
    end
  end

  assign slot_fault = f_ar_rdy | f_ar_r | f_r_rdy | f_r_last;

  always_comb begin
    fault_cause_o.ar_rdy   = |f_ar_rdy;
    fault_cause_o.ar_r     = |f_ar_r;
    fault_cause_o.r_rdy    = |f_r_rdy;
    fault_cause_o.r_last   = |f_r_last;
    fault_cause_o.unwanted = last_beat && !head_match;
  end

  // Record source is the lowest faulting slot, else the stray response
  always_comb begin
    fault_id_o   = r_id_i;
    fault_addr_o = slot_valid_i[head_i] ? slots_i[head_i].addr : '0;
    for (int i = Depth - 1; i >= 0; i--) begin
      if (slot_fault[i]) begin
        fault_id_o   = slots_i[i].id;
        fault_addr_o = slots_i[i].addr;
      end
    end
  end

  assign fault_o = |fault_cause_o;
  assign flush_o = fault_o && rd_guard_pkg::is_severe(fault_cause_o);
  assign pop_o   = complete && !flush_o;
  assign done_o  = pop_o && !tmo_q[head_i] && !slot_fault[head_i];

  assign lat_ar_rdy_o = cnt_ar_rdy_q[head_i];
  assign lat_ar_r_o   = cnt_ar_r_q[head_i];
  assign lat_r_rdy_o  = cnt_r_rdy_q[head_i];
  assign lat_r_last_o = cnt_r_last_q[head_i];

  // AR wait before the handshake, handed to the slot that the read gets
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ar_wait_q <= '0;
    end else if (tick_i) begin
      if (arr_i) begin
        ar_wait_q <= '0;
      end else if (arv_i) begin
        ar_wait_q <= ar_wait_q + 1'b1;
      end
    end
  end

  for (genvar i = 0; i < Depth; i++) begin : gen_slot
    logic is_head;
    assign is_head = (head_i == SlotW'(i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        phase_q[i]      <= rd_guard_pkg::PH_IDLE;
        tmo_q[i]        <= 1'b0;
        cnt_ar_rdy_q[i] <= '0;
        cnt_ar_r_q[i]   <= '0;
        cnt_r_rdy_q[i]  <= '0;
        cnt_r_last_q[i] <= '0;
      end else if (flush_o || (pop_o && is_head)) begin
        phase_q[i] <= rd_guard_pkg::PH_IDLE;
        tmo_q[i]   <= 1'b0;
      end else if (alloc_i && (alloc_slot_i == SlotW'(i))) begin
        phase_q[i]      <= rd_guard_pkg::PH_ADDR;
        tmo_q[i]        <= 1'b0;
        cnt_ar_rdy_q[i] <= ar_wait_q;
        cnt_ar_r_q[i]   <= '0;
        cnt_r_rdy_q[i]  <= '0;
        cnt_r_last_q[i] <= '0;
      end else if (tick_i && slot_valid_i[i]) begin
        // A timed-out read stays until its last beat but reports once
        tmo_q[i] <= tmo_q[i] | slot_fault[i];
        if (phase_q[i] == rd_guard_pkg::PH_ADDR) begin
          cnt_ar_r_q[i] <= cnt_ar_r_q[i] + 1'b1;
          if (is_head && rv_i && rr_i) begin
            phase_q[i] <= rd_guard_pkg::PH_DATA;
          end
        end else begin
          cnt_r_last_q[i] <= cnt_r_last_q[i] + 1'b1;
        end
        // Only the head can have beats waiting for R ready
        if (is_head && rv_i && !rr_i) begin
          cnt_r_rdy_q[i] <= cnt_r_rdy_q[i] + 1'b1;
        end
      end
    end
  end

endmodule

/* src/rd_txn_queue.sv */
/*
 * In-order queue of tracked reads. On enqueue it sums the beats still
 * outstanding and stores the read with both long-phase budgets scaled.
 */
`timescale 1ns/1ps
`include "rd_guard_defines.svh"

module rd_txn_queue (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      push_i,
  input  logic [`RG_ID_W-1:0]                       ar_id_i,
  input  logic [`RG_ADDR_W-1:0]                     ar_addr_i,
  input  logic [`RG_LEN_W-1:0]                      ar_len_i,
  input  logic [`RG_HS_CNT_W-1:0]                   budget_unit_r_i,
  input  logic                                      pop_i,
  input  logic                                      flush_i,
  output logic [`RG_MAX_TXNS-1:0]                   slot_valid_o,
  output rd_guard_pkg::rd_txn_t [`RG_MAX_TXNS-1:0]  slots_o,
  output logic [`RG_SLOT_W-1:0]                     head_o,
  output logic                                      alloc_o,
  output logic [`RG_SLOT_W-1:0]                     alloc_slot_o
);

  localparam int Depth = `RG_MAX_TXNS;
  localparam int SlotW = `RG_SLOT_W;
  localparam int CntW  = `RG_CNT_W;
  localparam int ProdW = `RG_CNT_W + `RG_HS_CNT_W;

  rd_guard_pkg::rd_txn_t [Depth-1:0] slots_q;

  logic [SlotW-1:0] wr_ptr_q;
  logic [SlotW-1:0] rd_ptr_q;
  logic [SlotW:0]   count_q;
  logic             full;
  logic             accept;
  logic [CntW-1:0]  beat_sum;
  logic [ProdW-1:0] budget_full;
  logic [CntW-1:0]  budget_scaled;

  assign full   = (count_q == (SlotW + 1)'(Depth));
  // A full queue drops the read, the bus itself is never stalled
  assign accept = push_i && !full && !flush_i;

  // A slot is live when it lies within count entries of the read pointer
  for (genvar i = 0; i < Depth; i++) begin : gen_valid
    logic [SlotW-1:0] offs;
    assign offs            = SlotW'(i) - rd_ptr_q;
    assign slot_valid_o[i] = ({1'b0, offs} < count_q);
  end

  // Beats of every tracked read plus the new one
  always_comb begin
    beat_sum = CntW'(ar_len_i) + 1'b1;
    for (int i = 0; i < Depth; i++) begin
      if (slot_valid_o[i]) begin
        beat_sum = beat_sum + CntW'(slots_q[i].len) + 1'b1;
      end
    end
  end

  assign budget_full   = ProdW'(budget_unit_r_i) * ProdW'(beat_sum);
  // Saturate instead of wrapping to a tiny budget
  assign budget_scaled = (|budget_full[ProdW-1:CntW]) ? '1 : budget_full[CntW-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (accept) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (SlotW + 1)'(accept) - (SlotW + 1)'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      slots_q[wr_ptr_q].id           <= ar_id_i;
      slots_q[wr_ptr_q].addr         <= ar_addr_i;
      slots_q[wr_ptr_q].len          <= ar_len_i;
      slots_q[wr_ptr_q].budget_first <= budget_scaled;
      slots_q[wr_ptr_q].budget_last  <= budget_scaled;
    end
  end

  assign slots_o      = slots_q;
  assign head_o       = rd_ptr_q;
  assign alloc_o      = accept;
  assign alloc_slot_o = wr_ptr_q;

  // The timer only completes a read it is tracking
  pop_not_empty_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> (count_q != '0)
  );

  // A severe fault suppresses the completion of that tick
  flush_pop_excl_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(flush_i && pop_i)
  );

endmodule

/* src/rd_sample_unit.sv */
/*
 * Prescaler and handshake sampler. Any handshake bit seen during a tick
 * window is held until the window closes, so the timers see it at the tick.
 */
`timescale 1ns/1ps
`include "rd_guard_defines.svh"

module rd_sample_unit (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ar_valid_i,
  input  logic ar_ready_i,
  input  logic r_valid_i,
  input  logic r_ready_i,
  input  logic r_last_i,
  output logic tick_o,
  output logic arv_o,
  output logic arr_o,
  output logic rv_o,
  output logic rr_o,
  output logic rl_o
);

  localparam int Div  = `RG_PRESCALE_DIV;
  localparam int DivW = (Div > 1) ? $clog2(Div) : 1;

  logic [DivW-1:0] div_q;
  logic [4:0]      raw;
  logic [4:0]      sticky_q;

  assign raw    = {ar_valid_i, ar_ready_i, r_valid_i, r_ready_i, r_last_i};
  assign tick_o = (div_q == DivW'(Div - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_q    <= '0;
      sticky_q <= '0;
    end else begin
      div_q <= tick_o ? '0 : div_q + 1'b1;
      // A new window starts with what is on the bus in the tick cycle
      sticky_q <= tick_o ? raw : (sticky_q | raw);
    end
  end

  assign {arv_o, arr_o, rv_o, rr_o, rl_o} = sticky_q;

  // The timers count one step per tick, so a wide tick would double count
  tick_single_cycle_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) tick_o |=> !tick_o
  );

endmodule

/* src/rd_guard_pkg.sv */
/*
 * Types shared by the read guard units: slot phase, tracked-read entry
 * and the fault cause record.
 */
`include "rd_guard_defines.svh"

package rd_guard_pkg;

  // Phase of one tracked read
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_ADDR,
    PH_DATA
  } rd_phase_e;

  // One tracked read, budgets already scaled at enqueue
  typedef struct packed {
    logic [`RG_ID_W-1:0]   id;
    logic [`RG_ADDR_W-1:0] addr;
    logic [`RG_LEN_W-1:0]  len;
    logic [`RG_CNT_W-1:0]  budget_first;
    logic [`RG_CNT_W-1:0]  budget_last;
  } rd_txn_t;

  // One bit per fault cause
  typedef struct packed {
    logic ar_rdy;
    logic ar_r;
    logic r_rdy;
    logic r_last;
    logic unwanted;
  } fault_cause_t;

  // Causes that request a subordinate reset and flush the tracked reads
  function automatic logic is_severe(fault_cause_t c);
    return c.ar_rdy | c.ar_r | c.r_last | c.unwanted;
  endfunction

endpackage

/* src/rd_guard_defines.svh */
/*
 * Widths, depths and the prescale divisor of the AXI read guard.
 * Included by every RTL file that sizes a port or a register.
 */
`ifndef RD_GUARD_DEFINES_SVH
`define RD_GUARD_DEFINES_SVH

// Bus fields
`define RG_ID_W 4
`define RG_ADDR_W 32
// Burst length field, beats are length plus one
`define RG_LEN_W 8

// Tracked reads and their slot index
`define RG_MAX_TXNS 4
`define RG_SLOT_W 2

// Long-phase counters and scaled budgets
`define RG_CNT_W 14
// Handshake counters and unit budgets
`define RG_HS_CNT_W 8

// Clock cycles per timer tick
`define RG_PRESCALE_DIV 4

`endif
